//--- dsp_sio.f
logic/dsp_sio_pkg.sv
logic/sio_clock_gen.sv
logic/sio_reg_file.sv
logic/sio_out_shift.sv
logic/dsp_sio_top.sv
sim/dsp_sio_assertions.sv
sim/dsp_sio_tb.sv

//--- sim/dsp_sio_tb.sv
`timescale 1ns/1ps
`default_nettype none

// random cpu writes against a cycle model of the registers, buffer and frames
module dsp_sio_tb;

    localparam int run_cycles  = 24000;
    localparam int drain_limit = 1000;     // clk cycles, several frames long
    localparam int min_frames  = 20;

    logic                 clk;
    logic                 rst;
    logic                 ph1;
    dsp_sio_pkg::cpu_wr_t cpu_wr;
    logic                 ock;
    logic                 sio_do;
    logic                 sadd;
    logic                 obe;
    logic                 ose;
    logic [15:0]          r_sio;

    logic [9:0]  m_sioc;
    logic [7:0]  m_srta;
    logic [15:0] m_buf;         // last sdx word
    logic        m_pend;        // word waiting in the buffer
    logic        m_ose;
    logic [15:0] exp_word;      // word of the running frame
    logic [7:0]  exp_addr;      // inverted srta latched at frame start
    logic        frame_on;
    logic        last_ock;
    int          bit_idx;
    int          rise_cnt;      // ock rises since reset, ring slot = rise_cnt % 16
    int          frames_done;
    int          phase_len;     // ph1 ticks at the current ock level
    int          phases_seen;
    int          err_cnt [5];   // regs, clock, data, flags, other

    dsp_sio_top dut_i (
        .clk    (clk),
        .rst    (rst),
        .ph1    (ph1),
        .cpu_wr (cpu_wr),
        .ock    (ock),
        .sio_do (sio_do),
        .sadd   (sadd),
        .obe    (obe),
        .ose    (ose),
        .r_sio  (r_sio)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic mismatch(input string test, input int cat,
                            input logic [15:0] expv, input logic [15:0] actv);
        err_cnt[cat]++;
        $display("ERROR %s expected %h actual %h at %0t", test, expv, actv, $time);
    endtask

    // called at each falling edge, before new inputs go out
    task automatic check_cycle();
        logic        rise;
        logic        fall;
        logic        start;
        logic        exp_do;
        logic        exp_sa;
        logic [15:0] wdata;
        logic [15:0] exp_r;
        rise  = ock && !last_ock;
        fall  = !ock && last_ock;
        start = 1'b0;
        if (ock !== last_ock && !ph1) begin
            err_cnt[1]++;
            $display("ock changed in a cycle without ph1 at %0t", $time);
        end
        if (ph1) begin
            if (ock !== last_ock) begin
                if (phases_seen > 0 && phase_len != 3) begin
                    mismatch("ock_phase", 1, 16'd3, 16'(phase_len));
                end
                phases_seen++;
                phase_len = 1;              // this tick opens the new level
            end else begin
                phase_len++;
            end
        end
        // frame boundary when the ring passes slot 15
        if (rise) begin
            if (rise_cnt % 16 == 15) begin
                start = m_pend;
                m_ose = !m_pend;
                if (m_pend) begin
                    exp_word = m_buf;
                    exp_addr = ~m_srta;     // srta before any write in this cycle
                    frame_on = 1'b1;
                    bit_idx  = 0;
                end
            end
            rise_cnt++;
        end
        if (fall) begin
            exp_do = 1'b0;                  // idle line shifts zeros
            exp_sa = 1'b1;
            if (frame_on) begin
                exp_do = exp_word[15 - bit_idx];
                exp_sa = (bit_idx < 8) ? exp_addr[7 - bit_idx] : 1'b1;
                bit_idx++;
                if (bit_idx == 16) begin
                    frame_on = 1'b0;
                    frames_done++;
                end
            end
            if (sio_do !== exp_do) begin
                mismatch("sio_do", 2, 16'(exp_do), 16'(sio_do));
            end
            if (sadd !== exp_sa) begin
                mismatch("sadd", 2, 16'(exp_sa), 16'(sadd));
            end
        end
        if (start) begin
            m_pend = 1'b0;
        end
        // cpu write, imm over acc over ram
        if (ph1 && (cpu_wr.imm_load || cpu_wr.acc_load || cpu_wr.ram_load)) begin
            wdata = cpu_wr.imm_load ? cpu_wr.long_imm :
                    cpu_wr.acc_load ? cpu_wr.acc_dout : cpu_wr.ram_dout;
            case (cpu_wr.r_field)
                3'd0: m_sioc = wdata[9:0];
                3'd1: m_srta = wdata[7:0];
                3'd2: begin
                    m_buf  = wdata;         // overwrites an unsent word
                    m_pend = 1'b1;
                end
                default: ;
            endcase
        end
        case (cpu_wr.r_field)
            3'd0:    exp_r = {6'd0, m_sioc};
            3'd1:    exp_r = {8'd0, m_srta};
            default: exp_r = 16'd0;
        endcase
        if (r_sio !== exp_r) begin
            mismatch("r_sio", 0, exp_r, r_sio);
        end
        if (obe !== !m_pend) begin
            mismatch("obe", 3, 16'(!m_pend), 16'(obe));
        end
        if (ose !== m_ose) begin
            mismatch("ose", 3, 16'(m_ose), 16'(ose));
        end
        last_ock = ock;
    endtask

    // random bus values, load strobes only when asked for
    task automatic drive_bus(input logic with_load, input logic [2:0] rfield);
        logic [2:0] src;
        ph1             = ($urandom % 4) != 0;   // high three ticks in four
        cpu_wr.long_imm = 16'($urandom);
        cpu_wr.acc_dout = 16'($urandom);
        cpu_wr.ram_dout = 16'($urandom);
        cpu_wr.r_field  = rfield;
        src = (with_load && ($urandom % 12 == 0)) ? 3'($urandom % 7 + 1) : 3'd0;
        {cpu_wr.imm_load, cpu_wr.acc_load, cpu_wr.ram_load} = src;
    endtask

    initial begin
        int waited;
        int total;
        void'($urandom(6));
        rst         = 1'b1;
        ph1         = 1'b0;
        cpu_wr      = '0;
        m_sioc      = '0;
        m_srta      = '0;
        m_buf       = '0;
        m_pend      = 1'b0;
        m_ose       = 1'b1;
        frame_on    = 1'b0;
        last_ock    = 1'b0;
        bit_idx     = 0;
        rise_cnt    = 0;
        frames_done = 0;
        phase_len   = 0;
        phases_seen = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        // reset state and read-back of every code
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_cycle();
            drive_bus(1'b0, 3'(i));
        end
        for (int n = 0; n < run_cycles; n++) begin
            @(negedge clk);
            check_cycle();
            drive_bus(1'b1, 3'($urandom));
        end
        // no more writes, let the last word leave
        waited = 0;
        while ((m_pend || frame_on) && waited < drain_limit) begin
            @(negedge clk);
            check_cycle();
            drive_bus(1'b0, 3'($urandom));
            waited++;
        end
        if (m_pend || frame_on) begin
            err_cnt[4]++;
            $display("timed out waiting for the last frame to go out");
        end
        if (frames_done < min_frames) begin
            err_cnt[4]++;
            $display("only %0d frames were sent, too few to trust the run", frames_done);
        end
        total = dut_i.assertions_i.fail_cnt;
        foreach (err_cnt[k]) begin
            total += err_cnt[k];
        end
        $display("errors regs %0d clock %0d data %0d flags %0d other %0d assertions %0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3], err_cnt[4],
                 dut_i.assertions_i.fail_cnt);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/dsp_sio_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the serial unit, bound into dsp_sio_top
module dsp_sio_assertions (
    input wire logic                           clk,
    input wire logic                           rst,
    input wire dsp_sio_pkg::ock_evt_t          ock_evt,
    input wire logic                           sdx_valid,  // sdx write this cycle
    input wire logic                           ock,
    input wire logic                           sio_do,
    input wire logic                           sadd,
    input wire logic                           obe,
    input wire logic                           ose,
    input wire logic [dsp_sio_pkg::data_w-1:0] r_sio
);

    int fail_cnt = 0;    // failed assertions so far

    // divider never strobes both edges at once
    strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(ock_evt.rise && ock_evt.fall))
        else begin
            fail_cnt++;
            $error("ock rise and fall strobes in the same cycle");
        end

    // serial pins only move on an ock rise
    pins_on_rise: assert property (@(posedge clk) disable iff (rst)
        !$past(ock_evt.rise) |-> ($stable(sio_do) && $stable(sadd)))
        else begin
            fail_cnt++;
            $error("sio_do or sadd changed without an ock rise");
        end

    // buffer only fills from an sdx write
    obe_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(obe) |-> $past(sdx_valid))
        else begin
            fail_cnt++;
            $error("obe dropped without an sdx write");
        end

    // shifter gets busy only when a word leaves the buffer
    ose_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(ose) |-> ($rose(obe) || $past(sdx_valid)))
        else begin
            fail_cnt++;
            $error("ose dropped without a word start");
        end

    no_x_out: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({ock, sio_do, sadd, obe, ose, r_sio}))
        else begin
            fail_cnt++;
            $error("unknown value on a dut output");
        end

endmodule

bind dsp_sio_top dsp_sio_assertions assertions_i (
    .clk       (clk),
    .rst       (rst),
    .ock_evt   (ock_evt),
    .sdx_valid (sdx_wr.valid),
    .ock       (ock),
    .sio_do    (sio_do),
    .sadd      (sadd),
    .obe       (obe),
    .ose       (ose),
    .r_sio     (r_sio)
);

`default_nettype wire

//--- logic/dsp_sio_top.sv
`timescale 1ns/1ps
`default_nettype none

// serial output unit of the dsp core
// cpu writes sdx / srta / sioc, data goes out on sio_do clocked by ock
module dsp_sio_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          ph1,     // core phase, used as enable
    input  wire dsp_sio_pkg::cpu_wr_t          cpu_wr,  // cpu write bus
    output logic                               ock,     // serial clock out
    output logic                               sio_do,  // serial data out
    output logic                               sadd,    // serial address out
    output logic                               obe,     // output buffer empty
    output logic                               ose,     // output shift reg empty
    output logic [dsp_sio_pkg::data_w-1:0]     r_sio    // register read-back
);

    dsp_sio_pkg::sdx_wr_t           sdx_wr;    // reg file to buffer
    dsp_sio_pkg::ock_evt_t          ock_evt;   // divider strobes
    logic [dsp_sio_pkg::srta_w-1:0] srta;      // stored address

    // ock divider
    sio_clock_gen clock_gen_i (
        .clk     (clk),
        .rst     (rst),
        .ph1     (ph1),
        .ock     (ock),
        .ock_evt (ock_evt)
    );

    // cpu registers and read-back
    sio_reg_file reg_file_i (
        .clk    (clk),
        .rst    (rst),
        .ph1    (ph1),
        .cpu_wr (cpu_wr),
        .sdx_wr (sdx_wr),
        .srta   (srta),
        .r_sio  (r_sio)
    );

    // buffer, shifters and status flags
    sio_out_shift out_shift_i (
        .clk     (clk),
        .rst     (rst),
        .sdx_wr  (sdx_wr),
        .srta    (srta),
        .ock_evt (ock_evt),
        .sio_do  (sio_do),
        .sadd    (sadd),
        .obe     (obe),
        .ose     (ose)
    );

endmodule

`default_nettype wire

//--- logic/sio_out_shift.sv
`timescale 1ns/1ps
`default_nettype none

// output buffer, shift register and frame timing
// frames are 16 ock periods long, a new word starts only at a frame boundary
module sio_out_shift (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire dsp_sio_pkg::sdx_wr_t          sdx_wr,   // already ph1 qualified
    input  wire logic [dsp_sio_pkg::srta_w-1:0] srta,
    input  wire dsp_sio_pkg::ock_evt_t         ock_evt,
    output logic                               sio_do,   // serial data, msb first
    output logic                               sadd,     // serial address bit
    output logic                               obe,      // output buffer empty
    output logic                               ose       // output shift reg empty
);

    logic [dsp_sio_pkg::data_w-1:0] obuf;       // output buffer
    logic [dsp_sio_pkg::data_w-1:0] odata;      // bits still to shift out
    logic [dsp_sio_pkg::data_w-1:0] ring;       // one-hot frame slot
    logic [dsp_sio_pkg::srta_w-1:0] addr_sr;    // inverted address, msb first
    logic                           frame_end;  // ring sits on slot 15
    logic                           word_start; // buffer moves to the shifter

    assign frame_end  = ring[dsp_sio_pkg::data_w-1];
    assign word_start = ock_evt.rise && frame_end && !obe;
    assign sadd       = addr_sr[dsp_sio_pkg::srta_w-1];

    // buffer holds the latest word, an unsent one is simply overwritten
    always_ff @(posedge clk) begin
        if (sdx_wr.valid) begin
            obuf <= sdx_wr.data;
        end
    end

    // frame ring rotates once per ock period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ring <= dsp_sio_pkg::data_w'(1);    // slot 0
        end else if (ock_evt.rise) begin
            ring <= {ring[dsp_sio_pkg::data_w-2:0], ring[dsp_sio_pkg::data_w-1]};
        end
    end

    // data and address shifters, both move on ock rise only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sio_do  <= 1'b0;
            odata   <= '0;
            addr_sr <= '1;                      // address line idles high
        end else if (ock_evt.rise) begin
            if (word_start) begin
                {sio_do, odata} <= {obuf, 1'b0};   // msb out right away
                addr_sr         <= ~srta;          // pin is active low
            end else begin
                {sio_do, odata} <= {odata, 1'b0};  // zeros once the word is gone
                addr_sr         <= {addr_sr[dsp_sio_pkg::srta_w-2:0], 1'b1};
            end
        end
    end

    // buffer empty flag
    // a write in the same cycle as a word start keeps the new word pending
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obe <= 1'b1;
        end else if (sdx_wr.valid) begin
            obe <= 1'b0;
        end else if (word_start) begin
            obe <= 1'b1;
        end
    end

    // shift register empty flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ose <= 1'b1;
        end else if (ock_evt.rise && frame_end) begin
            ose <= !word_start;    // busy for a new word, else the frame is done
        end
    end

endmodule

`default_nettype wire

//--- logic/sio_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

// cpu side of the serial unit
// picks the write source, decodes the register field and keeps sioc / srta
module sio_reg_file (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          ph1,
    input  wire dsp_sio_pkg::cpu_wr_t          cpu_wr,
    output dsp_sio_pkg::sdx_wr_t               sdx_wr,  // data register write request
    output logic [dsp_sio_pkg::srta_w-1:0]     srta,    // serial address
    output logic [dsp_sio_pkg::data_w-1:0]     r_sio    // read-back
);

    logic                              any_load;   // some source strobe is up
    logic                              wr_en;      // write qualified by ph1
    logic [dsp_sio_pkg::data_w-1:0]    wr_data;    // selected source
    logic                              sioc_wr;
    logic                              srta_wr;
    logic [dsp_sio_pkg::sioc_w-1:0]    sioc;       // stored only, config is fixed

    assign any_load = cpu_wr.imm_load || cpu_wr.acc_load || cpu_wr.ram_load;
    assign wr_en    = ph1 && any_load;

    // imm beats acc beats ram
    always_comb begin
        if (cpu_wr.imm_load) begin
            wr_data = cpu_wr.long_imm;
        end else if (cpu_wr.acc_load) begin
            wr_data = cpu_wr.acc_dout;
        end else begin
            wr_data = cpu_wr.ram_dout;
        end
    end

    // register decode, unknown codes fall through and are dropped
    assign sioc_wr = wr_en && (cpu_wr.r_field == dsp_sio_pkg::rf_sioc);
    assign srta_wr = wr_en && (cpu_wr.r_field == dsp_sio_pkg::rf_srta);

    // sdx write goes straight to the output buffer in the same cycle
    always_comb begin
        sdx_wr.valid = wr_en && (cpu_wr.r_field == dsp_sio_pkg::rf_sdx);
        sdx_wr.data  = wr_data;
    end

    // control registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sioc <= '0;
            srta <= '0;
        end else begin
            if (sioc_wr) begin
                sioc <= wr_data[dsp_sio_pkg::sioc_w-1:0];   // low bits only
            end
            if (srta_wr) begin
                srta <= wr_data[dsp_sio_pkg::srta_w-1:0];
            end
        end
    end

    // read-back mux, no serial input so everything else reads zero
    always_comb begin
        case (cpu_wr.r_field)
            dsp_sio_pkg::rf_sioc: r_sio = dsp_sio_pkg::data_w'(sioc);
            dsp_sio_pkg::rf_srta: r_sio = dsp_sio_pkg::data_w'(srta);
            default:              r_sio = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/sio_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// divide-by-six output clock
// the counter only moves in ph1 cycles so ock runs at ph1 rate / 6
module sio_clock_gen (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  ph1,    // clock enable from the core
    output logic                       ock,    // serial output clock pin
    output dsp_sio_pkg::ock_evt_t      ock_evt // edge strobes for the shifter
);

    logic [dsp_sio_pkg::ock_cnt_w-1:0] div_cnt;  // 0..ock_div-1
    logic                              cnt_wrap;

    assign cnt_wrap = div_cnt == dsp_sio_pkg::ock_cnt_w'(dsp_sio_pkg::ock_div - 1);

    // divider count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (ph1) begin
            if (cnt_wrap) begin
                div_cnt <= '0;                   // wrap after 5
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // strobes valid only in a ph1 cycle
    always_comb begin
        ock_evt.rise = ph1 && (div_cnt == dsp_sio_pkg::ock_rise_cnt);
        ock_evt.fall = ph1 && (div_cnt == dsp_sio_pkg::ock_fall_cnt);
    end

    // pin follows the strobes, three ph1 cycles high and three low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ock <= 1'b0;
        end else begin
            if (ock_evt.rise) begin
                ock <= 1'b1;
            end
            if (ock_evt.fall) begin
                ock <= 1'b0;                     // never both in one cycle
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/dsp_sio_pkg.sv
`default_nettype none

package dsp_sio_pkg;

    // data path widths
    localparam int data_w   = 16;              // cpu data bus
    localparam int sioc_w   = 10;              // serial i/o control
    localparam int srta_w   = 8;               // serial address
    localparam int rfield_w = 3;               // register select field

    // register field codes on the write bus
    localparam logic [rfield_w-1:0] rf_sioc = 3'd0;
    localparam logic [rfield_w-1:0] rf_srta = 3'd1;
    localparam logic [rfield_w-1:0] rf_sdx  = 3'd2;

    // output clock divider, counted in ph1 ticks
    localparam int ock_div      = 6;
    localparam int ock_cnt_w    = $clog2(ock_div);  // 3 bits hold 0..5
    localparam int ock_rise_cnt = 2;               // ock goes high here
    localparam int ock_fall_cnt = 5;               // and low here

    // cpu write bus, sources plus strobes and register select
    typedef struct packed {
        logic [data_w-1:0]   long_imm;
        logic [data_w-1:0]   acc_dout;
        logic [data_w-1:0]   ram_dout;
        logic                imm_load;
        logic                acc_load;
        logic                ram_load;
        logic [rfield_w-1:0] r_field;
    } cpu_wr_t;

    // write request into the serial data register
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
    } sdx_wr_t;

    // one-cycle edge strobes of the divided clock
    typedef struct packed {
        logic rise;
        logic fall;
    } ock_evt_t;

endpackage

`default_nettype wire
